/* common/game_pkg.sv */
package game_pkg;

    // one-hot, one bit per key and LED; zero is silence
    typedef logic [3:0] note_t;

    // longest level in notes
    localparam int max_notes = 6;

    typedef logic [3:0] level_t;

    // element max_notes-1 plays first
    typedef note_t [max_notes-1:0] sequence_t;

    // remaining notes in a level
    typedef logic [2:0] count_t;

    typedef enum logic [3:0] {
        st_start,
        st_select,
        st_fetch,
        st_challenge,
        st_wait,
        st_check,
        st_advance,
        st_won,
        st_lost
    } state_t;

endpackage

/* common/display_pkg.sv */
package display_pkg;

    // active low, bit 6 is segment g, bit 0 is segment a
    typedef logic [6:0] segments_t;

    localparam segments_t glyph_h     = 7'b000_1001;
    localparam segments_t glyph_e     = 7'b000_0110;
    localparam segments_t glyph_l     = 7'b100_0111;
    localparam segments_t glyph_o     = 7'b100_0000;
    localparam segments_t glyph_s     = 7'b001_0010;
    localparam segments_t glyph_t     = 7'b000_0111;
    localparam segments_t glyph_a     = 7'b000_1000;
    localparam segments_t glyph_g     = 7'b100_0010;
    localparam segments_t glyph_u     = 7'b110_0011;
    localparam segments_t glyph_r     = 7'b010_1111;
    localparam segments_t glyph_n     = 7'b010_1011;
    localparam segments_t glyph_c     = 7'b100_0110;
    localparam segments_t glyph_blank = 7'b111_1111;

    function automatic segments_t hex_glyph(input logic [3:0] digit);
        case (digit)
            4'h0: return 7'b100_0000;
            4'h1: return 7'b111_1001;
            4'h2: return 7'b010_0100;
            4'h3: return 7'b011_0000;
            4'h4: return 7'b001_1001;
            4'h5: return 7'b001_0010;
            4'h6: return 7'b000_0010;
            4'h7: return 7'b111_1000;
            4'h8: return 7'b000_0000;
            4'h9: return 7'b001_1000;
            4'ha: return 7'b000_1000;
            4'hb: return 7'b000_0011;
            4'hc: return 7'b100_0110;
            4'hd: return 7'b010_0001;
            4'he: return 7'b000_0110;
            default: return 7'b000_1110;
        endcase
    endfunction

endpackage

/* game/note_sequencer.sv */
`timescale 1ns/1ps

module note_sequencer (
    input  logic                clk,
    input  logic                load,
    input  logic                restart,
    input  logic                step,
    input  game_pkg::sequence_t note_seq,
    input  game_pkg::count_t    note_count,
    output game_pkg::note_t     note,
    output game_pkg::count_t    remaining
);

    game_pkg::sequence_t shift_reg;

    always_ff @(posedge clk or posedge load)
    begin
        if (load)
        begin
            shift_reg <= '0;
            remaining <= '0;
        end
        else if (restart)
        begin
            shift_reg <= note_seq;
            remaining <= note_count;
        end
        else if (step)
        begin
            // head leaves, silence fills from the tail
            shift_reg <= {shift_reg[game_pkg::max_notes-2:0], 4'b0000};
            if (remaining != '0)
                remaining <= remaining - 1'b1;
        end
    end

    assign note = shift_reg[game_pkg::max_notes-1];

endmodule

/* game/game_controller.sv */
`timescale 1ns/1ps

module game_controller #(
    parameter int win_pause = 50000000
) (
    input  logic             clk,
    input  logic             load,
    input  logic             start,
    input  logic             done_playback,
    input  logic             key_pressed,
    input  logic             mistake,
    input  logic             done_response,
    output game_pkg::state_t state,
    output logic             advance_level,
    output logic             fetch_level,
    output logic             play_enable,
    output logic             check_note,
    output logic             advance_note
);

    localparam int pause_w = (win_pause > 1) ? $clog2(win_pause) : 1;

    game_pkg::state_t   next_state;
    logic               won_last;
    logic [pause_w-1:0] pause_count;
    logic               pause_done;

    assign pause_done = (pause_count == pause_w'(win_pause - 1));

    always_comb
    begin
        case (state)
            game_pkg::st_start:     next_state = start ? game_pkg::st_select : game_pkg::st_start;
            game_pkg::st_select:    next_state = game_pkg::st_fetch;
            game_pkg::st_fetch:     next_state = game_pkg::st_challenge;
            game_pkg::st_challenge:
                next_state = done_playback ? game_pkg::st_wait : game_pkg::st_challenge;
            game_pkg::st_wait:
            begin
                if (done_response)
                    next_state = game_pkg::st_won;
                else if (key_pressed)
                    next_state = game_pkg::st_check;
                else
                    next_state = game_pkg::st_wait;
            end
            game_pkg::st_check:     next_state = mistake ? game_pkg::st_lost : game_pkg::st_advance;
            game_pkg::st_advance:   next_state = game_pkg::st_wait;
            game_pkg::st_won:       next_state = pause_done ? game_pkg::st_select : game_pkg::st_won;
            game_pkg::st_lost:      next_state = game_pkg::st_lost;
            default:                next_state = game_pkg::st_start;
        endcase
    end

    always_ff @(posedge clk or posedge load)
    begin
        if (load)
        begin
            state    <= game_pkg::st_start;
            won_last <= 1'b0;
        end
        else
        begin
            state    <= next_state;
            won_last <= (state == game_pkg::st_won);
        end
    end

    // pause counter only runs while the win message is up
    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            pause_count <= '0;
        else if (state == game_pkg::st_won && !pause_done)
            pause_count <= pause_count + 1'b1;
        else
            pause_count <= '0;
    end

    // first select after reset keeps the chosen level
    assign advance_level = (state == game_pkg::st_select) && won_last;
    assign fetch_level   = (state == game_pkg::st_fetch);
    assign play_enable   = (state == game_pkg::st_challenge);
    assign check_note    = (state == game_pkg::st_check);
    assign advance_note  = (state == game_pkg::st_advance);

endmodule

/* game/level_store.sv */
`timescale 1ns/1ps

module level_store (
    input  logic                clk,
    input  logic                load,
    input  game_pkg::level_t    level_select,
    input  logic                advance_level,
    output game_pkg::sequence_t note_seq,
    output game_pkg::count_t    note_count,
    output game_pkg::level_t    level_number
);

    localparam int rand_w = 2 * game_pkg::max_notes;

    // used for levels 4 and up until the first win draws a fresh one
    localparam game_pkg::sequence_t seed_seq = {4'd1, 4'd4, 4'd2, 4'd8, 4'd2, 4'd4};

    logic [rand_w-1:0]   free_count;
    game_pkg::sequence_t random_seq;

    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            free_count <= '0;
        else
            free_count <= free_count + 1'b1;
    end

    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            level_number <= (level_select == '0) ? 4'd1 : level_select;
        else if (advance_level)
            level_number <= level_number + 1'b1;
    end

    // two counter bits per note, mapped to one-hot
    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            random_seq <= seed_seq;
        else if (advance_level)
        begin
            for (int i = 0; i < game_pkg::max_notes; i++)
                random_seq[i] <= game_pkg::note_t'(4'b0001 << free_count[2*i +: 2]);
        end
    end

    always_comb
    begin
        case (level_number)
            4'd1:
            begin
                note_seq   = {4'd1, 4'd2, 4'd4, 4'd8, 4'd0, 4'd0};
                note_count = 3'd4;
            end
            4'd2:
            begin
                note_seq   = {4'd1, 4'd2, 4'd2, 4'd1, 4'd1, 4'd0};
                note_count = 3'd5;
            end
            4'd3:
            begin
                note_seq   = {4'd4, 4'd2, 4'd1, 4'd4, 4'd2, 4'd1};
                note_count = 3'd6;
            end
            default:
            begin
                note_seq   = random_seq;
                note_count = game_pkg::count_t'(game_pkg::max_notes);
            end
        endcase
    end

endmodule

/* verilog/note_playback.sv */
`timescale 1ns/1ps

module note_playback #(
    parameter int note_period = 25000000
) (
    input  logic                clk,
    input  logic                load,
    input  logic                fetch_level,
    input  logic                play_enable,
    input  game_pkg::sequence_t note_seq,
    input  game_pkg::count_t    note_count,
    output game_pkg::note_t     note,
    output logic                done_playback
);

    localparam int div_w = (note_period > 1) ? $clog2(note_period) : 1;

    logic [div_w-1:0] divider;
    logic             div_end;
    logic             rest_phase;
    logic             step;
    game_pkg::note_t  head_note;
    game_pkg::count_t remaining;

    assign div_end = (divider == div_w'(note_period - 1));
    // advance only after the rest half of each slot
    assign step    = play_enable && div_end && rest_phase;

    always_ff @(posedge clk or posedge load)
    begin
        if (load)
        begin
            divider    <= '0;
            rest_phase <= 1'b0;
        end
        else if (fetch_level)
        begin
            divider    <= '0;
            rest_phase <= 1'b0;
        end
        else if (play_enable)
        begin
            if (div_end)
            begin
                divider    <= '0;
                rest_phase <= ~rest_phase;
            end
            else
                divider <= divider + 1'b1;
        end
    end

    note_sequencer u_note_sequencer (
        .clk        (clk),
        .load       (load),
        .restart    (fetch_level),
        .step       (step),
        .note_seq   (note_seq),
        .note_count (note_count),
        .note       (head_note),
        .remaining  (remaining)
    );

    assign note          = rest_phase ? 4'b0000 : head_note;
    assign done_playback = (remaining == '0);

endmodule

/* verilog/response_checker.sv */
`timescale 1ns/1ps

module response_checker (
    input  logic                clk,
    input  logic                load,
    input  game_pkg::note_t     keys,
    input  logic                fetch_level,
    input  logic                check_note,
    input  logic                advance_note,
    input  game_pkg::sequence_t note_seq,
    input  game_pkg::count_t    note_count,
    output game_pkg::note_t     key_reg,
    output logic                key_pressed,
    output logic                mistake,
    output logic                done_response
);

    game_pkg::note_t  key_prev;
    game_pkg::note_t  pressed_note;
    game_pkg::note_t  expected_note;
    game_pkg::count_t remaining;

    // rising edge of any key after all were released
    assign key_pressed = (key_reg != '0) && (key_prev == '0);

    always_ff @(posedge clk or posedge load)
    begin
        if (load)
        begin
            key_reg      <= '0;
            key_prev     <= '0;
            pressed_note <= '0;
        end
        else
        begin
            key_reg  <= keys;
            key_prev <= key_reg;
            if (key_pressed)
                pressed_note <= key_reg;
        end
    end

    note_sequencer u_note_sequencer (
        .clk        (clk),
        .load       (load),
        .restart    (fetch_level),
        .step       (advance_note),
        .note_seq   (note_seq),
        .note_count (note_count),
        .note       (expected_note),
        .remaining  (remaining)
    );

    assign mistake       = check_note && (pressed_note != expected_note);
    assign done_response = (remaining == '0);

endmodule

/* verilog/message_display.sv */
`timescale 1ns/1ps

module message_display (
    input  game_pkg::state_t                  state,
    input  game_pkg::level_t                  level_number,
    output display_pkg::segments_t [5:0]      hex
);

    display_pkg::segments_t level_digit;

    assign level_digit = display_pkg::hex_glyph(level_number);

    // leftmost digit first
    always_comb
    begin
        case (state)
            game_pkg::st_start:
                hex = {display_pkg::glyph_h, display_pkg::glyph_e, display_pkg::glyph_l,
                       display_pkg::glyph_l, display_pkg::glyph_o, display_pkg::glyph_blank};
            game_pkg::st_challenge:
                hex = {display_pkg::glyph_s, display_pkg::glyph_t, display_pkg::glyph_a,
                       display_pkg::glyph_g, display_pkg::glyph_e, level_digit};
            game_pkg::st_wait:
                hex = {display_pkg::glyph_t, display_pkg::glyph_u, display_pkg::glyph_r,
                       display_pkg::glyph_n, display_pkg::glyph_blank,
                       display_pkg::glyph_blank};
            game_pkg::st_won:
                hex = {display_pkg::glyph_s, display_pkg::glyph_c, display_pkg::glyph_o,
                       display_pkg::glyph_r, display_pkg::glyph_e, display_pkg::glyph_blank};
            game_pkg::st_lost:
                hex = {display_pkg::glyph_l, display_pkg::glyph_o, display_pkg::glyph_s,
                       display_pkg::glyph_e, display_pkg::glyph_blank,
                       display_pkg::glyph_blank};
            default:
                hex = {6{display_pkg::glyph_blank}};
        endcase
    end

endmodule

/* verilog/memory_game.sv */
`timescale 1ns/1ps

module memory_game #(
    parameter int note_period = 25000000,
    parameter int win_pause   = 50000000
) (
    input  logic                              clk,
    input  logic                              load,
    input  logic                              start,
    input  game_pkg::level_t                  level_select,
    input  game_pkg::note_t                   keys,
    output game_pkg::note_t                   leds,
    output display_pkg::segments_t [5:0]      hex
);

    game_pkg::state_t    state;
    game_pkg::sequence_t note_seq;
    game_pkg::count_t    note_count;
    game_pkg::level_t    level_number;
    game_pkg::note_t     play_note;
    game_pkg::note_t     key_reg;
    logic                advance_level;
    logic                fetch_level;
    logic                play_enable;
    logic                check_note;
    logic                advance_note;
    logic                done_playback;
    logic                key_pressed;
    logic                mistake;
    logic                done_response;

    // playback owns the LEDs only while the sequence is shown
    assign leds = (state == game_pkg::st_challenge) ? play_note : key_reg;

    game_controller #(
        .win_pause(win_pause)
    ) u_game_controller (
        .clk           (clk),
        .load          (load),
        .start         (start),
        .done_playback (done_playback),
        .key_pressed   (key_pressed),
        .mistake       (mistake),
        .done_response (done_response),
        .state         (state),
        .advance_level (advance_level),
        .fetch_level   (fetch_level),
        .play_enable   (play_enable),
        .check_note    (check_note),
        .advance_note  (advance_note)
    );

    level_store u_level_store (
        .clk           (clk),
        .load          (load),
        .level_select  (level_select),
        .advance_level (advance_level),
        .note_seq      (note_seq),
        .note_count    (note_count),
        .level_number  (level_number)
    );

    note_playback #(
        .note_period(note_period)
    ) u_note_playback (
        .clk           (clk),
        .load          (load),
        .fetch_level   (fetch_level),
        .play_enable   (play_enable),
        .note_seq      (note_seq),
        .note_count    (note_count),
        .note          (play_note),
        .done_playback (done_playback)
    );

    response_checker u_response_checker (
        .clk           (clk),
        .load          (load),
        .keys          (keys),
        .fetch_level   (fetch_level),
        .check_note    (check_note),
        .advance_note  (advance_note),
        .note_seq      (note_seq),
        .note_count    (note_count),
        .key_reg       (key_reg),
        .key_pressed   (key_pressed),
        .mistake       (mistake),
        .done_response (done_response)
    );

    message_display u_message_display (
        .state        (state),
        .level_number (level_number),
        .hex          (hex)
    );

endmodule

/* tb/tb_memory_game.sv */
`timescale 1ns/1ps

module tb_memory_game;

    localparam int note_period = 4;
    localparam int win_pause   = 8;

    logic                         clk;
    logic                         load;
    logic                         start;
    game_pkg::level_t             level_select;
    game_pkg::note_t              keys;
    game_pkg::note_t              leds;
    display_pkg::segments_t [5:0] hex;

    game_pkg::note_t played[$];
    game_pkg::note_t expected_notes[$];

    // leftmost digit in the top bits
    localparam logic [41:0] msg_hello = {display_pkg::glyph_h, display_pkg::glyph_e,
        display_pkg::glyph_l, display_pkg::glyph_l, display_pkg::glyph_o, display_pkg::glyph_blank};
    localparam logic [41:0] msg_turn = {display_pkg::glyph_t, display_pkg::glyph_u,
        display_pkg::glyph_r, display_pkg::glyph_n, display_pkg::glyph_blank,
        display_pkg::glyph_blank};
    localparam logic [41:0] msg_score = {display_pkg::glyph_s, display_pkg::glyph_c,
        display_pkg::glyph_o, display_pkg::glyph_r, display_pkg::glyph_e, display_pkg::glyph_blank};
    localparam logic [41:0] msg_lose = {display_pkg::glyph_l, display_pkg::glyph_o,
        display_pkg::glyph_s, display_pkg::glyph_e, display_pkg::glyph_blank,
        display_pkg::glyph_blank};

    memory_game #(
        .note_period(note_period),
        .win_pause  (win_pause)
    ) u_memory_game (
        .clk          (clk),
        .load         (load),
        .start        (start),
        .level_select (level_select),
        .keys         (keys),
        .leds         (leds),
        .hex          (hex)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // standard active-low digits, segment a in bit 0
    function automatic logic [6:0] digit_segments(input int digit);
        case (digit)
            0: return 7'b100_0000;
            1: return 7'b111_1001;
            2: return 7'b010_0100;
            3: return 7'b011_0000;
            4: return 7'b001_1001;
            5: return 7'b001_0010;
            6: return 7'b000_0010;
            7: return 7'b111_1000;
            8: return 7'b000_0000;
            9: return 7'b001_0000;
            default: return 7'b111_1111;
        endcase
    endfunction

    function automatic logic [41:0] stage_msg(input int level);
        return {display_pkg::glyph_s, display_pkg::glyph_t, display_pkg::glyph_a,
                display_pkg::glyph_g, display_pkg::glyph_e, digit_segments(level)};
    endfunction

    function automatic bit is_one_hot(input game_pkg::note_t n);
        return (n != 4'd0) && ((n & (n - 4'd1)) == 4'd0);
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected)
            fail_run($sformatf("[ERROR] time %0t: %s got 0x%0h expected 0x%0h",
                               $time, name, actual, expected));
    endtask

    // inputs change 2 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic apply_reset(input game_pkg::level_t level);
        level_select = level;
        keys         = 4'd0;
        start        = 1'b0;
        load         = 1'b1;
        repeat (4) step_cycle();
        load = 1'b0;
    endtask

    task automatic pulse_start();
        start = 1'b1;
        step_cycle();
        start = 1'b0;
    endtask

    task automatic wait_for_hex(input logic [41:0] target, input string what, input int limit);
        int cycles;
        cycles = 0;
        while (hex !== target)
        begin
            if (cycles >= limit)
                fail_run($sformatf("timeout: display never showed %s", what));
            step_cycle();
            cycles++;
        end
    endtask

    // log each note that follows silence while the stage message is up
    task automatic record_playback(input int level);
        game_pkg::note_t last;
        int              cycles;
        played.delete();
        last   = 4'd0;
        cycles = 0;
        wait_for_hex(stage_msg(level), $sformatf("StAGE %0d", level), 100);
        while (hex === stage_msg(level))
        begin
            if (cycles >= 300)
                fail_run($sformatf("timeout: playback of level %0d never ended", level));
            if (leds != 4'd0 && last == 4'd0)
                played.push_back(leds);
            last = leds;
            step_cycle();
            cycles++;
        end
        check_value("hex", hex, msg_turn);
    endtask

    task automatic check_playback();
        check_value("playback length", played.size(), expected_notes.size());
        foreach (expected_notes[i])
            check_value($sformatf("leds note %0d", i), played[i], expected_notes[i]);
    endtask

    task automatic press_key(input game_pkg::note_t key);
        keys = key;
        repeat (2) step_cycle();
        keys = 4'd0;
        repeat (2) step_cycle();
    endtask

    task automatic respond(input game_pkg::note_t key);
        wait_for_hex(msg_turn, "turn", 50);
        press_key(key);
    endtask

    task automatic echo_playback();
        foreach (played[i])
            respond(played[i]);
        wait_for_hex(msg_score, "SCOrE", 20);
    endtask

    task automatic count_win_pause(output int cycles);
        cycles = 0;
        while (hex === msg_score)
        begin
            if (cycles > 4 * win_pause)
                fail_run("timeout: win pause never ended");
            step_cycle();
            cycles++;
        end
    endtask

    task automatic test_after_reset();
        apply_reset(4'd1);
        check_value("hex", hex, msg_hello);
        check_value("leds", leds, 4'd0);
        keys = 4'b0010;
        check_value("leds", leds, 4'd0);
        step_cycle();
        check_value("leds", leds, 4'b0010);
        keys = 4'd0;
        step_cycle();
        check_value("leds", leds, 4'd0);
        check_value("hex", hex, msg_hello);
    endtask

    task automatic test_level1_playback();
        pulse_start();
        record_playback(1);
        expected_notes = '{4'd1, 4'd2, 4'd4, 4'd8};
        check_playback();
    endtask

    task automatic test_correct_response();
        int pause_cycles;
        echo_playback();
        count_win_pause(pause_cycles);
        check_value("win pause cycles", pause_cycles, win_pause);
        record_playback(2);
        expected_notes = '{4'd1, 4'd2, 4'd2, 4'd1, 4'd1};
        check_playback();
    endtask

    task automatic test_wrong_note();
        int              pick;
        game_pkg::note_t wrong;
        apply_reset(4'd3);
        pulse_start();
        record_playback(3);
        expected_notes = '{4'd4, 4'd2, 4'd1, 4'd4, 4'd2, 4'd1};
        check_playback();
        // any key but the first note of level 3
        pick = $urandom % 3;
        case (pick)
            0: wrong = 4'b0001;
            1: wrong = 4'b0010;
            default: wrong = 4'b1000;
        endcase
        respond(wrong);
        wait_for_hex(msg_lose, "LOSE", 10);
        press_key(4'b0100);
        pulse_start();
        press_key(wrong);
        repeat (10)
        begin
            check_value("hex", hex, msg_lose);
            step_cycle();
        end
    endtask

    task automatic test_random_level();
        apply_reset(4'd4);
        pulse_start();
        record_playback(4);
        check_value("playback length", played.size(), game_pkg::max_notes);
        foreach (played[i])
            check_value($sformatf("one-hot note %0d", i), is_one_hot(played[i]), 1'b1);
        echo_playback();
    endtask

    initial
    begin
        load         = 1'b1;
        start        = 1'b0;
        level_select = 4'd1;
        keys         = 4'd0;
        void'($urandom(38024));

        test_after_reset();
        test_level1_playback();
        test_correct_response();
        test_wrong_note();
        test_random_level();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* src.f */
common/game_pkg.sv
common/display_pkg.sv
game/note_sequencer.sv
game/game_controller.sv
game/level_store.sv
verilog/note_playback.sv
verilog/response_checker.sv
verilog/message_display.sv
verilog/memory_game.sv
tb/tb_memory_game.sv

/* run.sh */
#!/bin/sh
# Build and run the memory game testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f src.f \
        --top-module tb_memory_game -o sim_memory_game; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/sim_memory_game)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1
